/* build.sh */
#!/bin/sh
# Compile and run the hybrid predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_hybrid_predictor -f hybrid_bp.f -o tb_hybrid_predictor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_hybrid_predictor > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

/* hybrid_bp.f */
src/bp_pkg.sv
src/branch_classify.sv
src/branch_target_buffer.sv
src/gshare_predictor.sv
src/local_history_predictor.sv
src/tournament_chooser.sv
src/return_stack.sv
src/hybrid_predictor.sv
test/tb_hybrid_predictor.sv

/* src/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    typedef logic [31:0] addr_t;       // Instruction address
    typedef logic [31:0] instr_t;      // Instruction word
    typedef logic [1:0]  ctr_t;        // 2-bit saturating counter
    typedef logic [1:0]  pred_bits_t;  // {global dir, local dir}

    // Default table sizes that the top level overrides
    parameter int BTB_IDX_W     = 6;   // 64 BTB entries
    parameter int GHR_W         = 8;   // 256 gshare counters
    parameter int LHIST_W       = 6;   // Local history length
    parameter int LOCAL_IDX_W   = 6;   // 64 local history entries
    parameter int CHOOSER_IDX_W = 8;
    parameter int RAS_DEPTH     = 8;

    // Weakly not taken or weakly prefer local in the chooser
    localparam ctr_t CTR_INIT = 2'd1;

    // One saturating step toward up or down
    function automatic ctr_t ctr_step(ctr_t c, logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

endpackage

`default_nettype wire

/* src/branch_classify.sv */
`default_nettype none

module branch_classify (
    input  wire bp_pkg::instr_t instr,
    output logic                is_branch,
    output logic                is_jump,
    output logic                is_call,
    output logic                is_return
);
    typedef logic [5:0] opcode_t;
    typedef logic [4:0] reg_t;

    localparam opcode_t OP_SPECIAL = 6'd0;
    localparam opcode_t OP_J       = 6'd2;
    localparam opcode_t OP_JAL     = 6'd3;
    localparam logic [5:0] FUNCT_JR = 6'd8;
    localparam reg_t   REG_RA      = 5'd31;

    opcode_t opcode;
    reg_t    rs;
    logic    jr_ra;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign jr_ra  = (opcode == OP_SPECIAL) && (instr[5:0] == FUNCT_JR) && (rs == REG_RA);

    always_comb begin
        // REGIMM, beq, bne, blez, bgtz
        case (opcode)
            6'd1, 6'd4, 6'd5, 6'd6, 6'd7: is_branch = 1'b1;
            default:                       is_branch = 1'b0;
        endcase
    end

    assign is_call   = (opcode == OP_JAL);
    assign is_return = jr_ra;
    assign is_jump   = (opcode == OP_J) || (opcode == OP_JAL) || jr_ra;  // Returns count as jumps

endmodule

`default_nettype wire

/* src/branch_target_buffer.sv */
`default_nettype none

module branch_target_buffer #(
    parameter int BTB_IDX_W = bp_pkg::BTB_IDX_W
) (
    input  wire logic          CLK,
    input  wire logic          RESET,
    input  wire logic          flush,
    input  wire bp_pkg::addr_t lookup_pc,
    output logic               hit,
    output bp_pkg::addr_t      target,
    input  wire logic          write_en,
    input  wire bp_pkg::addr_t write_pc,
    input  wire bp_pkg::addr_t write_target
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << BTB_IDX_W;
    localparam int TAG_W   = 32 - BTB_IDX_W - 2;  // Everything above the index

    typedef logic [BTB_IDX_W-1:0] btb_idx_t;
    typedef logic [TAG_W-1:0]     btb_tag_t;

    logic [ENTRIES-1:0] valid_q;
    btb_tag_t           tag_q    [ENTRIES];
    addr_t              target_q [ENTRIES];

    btb_idx_t lookup_idx;
    btb_idx_t write_idx;
    btb_tag_t lookup_tag;
    btb_tag_t write_tag;

    assign lookup_idx = lookup_pc[BTB_IDX_W+1:2];
    assign lookup_tag = lookup_pc[31:BTB_IDX_W+2];
    assign write_idx  = write_pc[BTB_IDX_W+1:2];
    assign write_tag  = write_pc[31:BTB_IDX_W+2];

    // Read is combinational, so a same-cycle write is seen next cycle
    assign hit    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target = target_q[lookup_idx];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;  // Forget every entry
        end else if (write_en) begin
            valid_q[write_idx] <= 1'b1;
        end
    end

    // Tag and target storage
    always_ff @(posedge CLK) begin
        if (write_en) begin
            tag_q[write_idx]    <= write_tag;
            target_q[write_idx] <= write_target;
        end
    end

endmodule

`default_nettype wire

/* src/gshare_predictor.sv */
`default_nettype none

module gshare_predictor #(
    parameter int GHR_W = bp_pkg::GHR_W
) (
    input  wire logic          CLK,
    input  wire logic          RESET,
    input  wire bp_pkg::addr_t lookup_pc,
    output logic               taken,
    input  wire logic          update_en,
    input  wire bp_pkg::addr_t update_pc,
    input  wire logic          update_taken
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << GHR_W;

    typedef logic [GHR_W-1:0] ghr_t;

    ghr_t ghr_q;                 // Global history with the newest outcome in bit 0
    ctr_t pht_q [ENTRIES];

    ghr_t lookup_idx;
    ghr_t update_idx;

    assign lookup_idx = ghr_q ^ lookup_pc[GHR_W+1:2];
    // History before this resolve's shift
    assign update_idx = ghr_q ^ update_pc[GHR_W+1:2];

    assign taken = pht_q[lookup_idx][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ghr_q <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                pht_q[i] <= CTR_INIT;
            end
        end else if (update_en) begin
            pht_q[update_idx] <= ctr_step(pht_q[update_idx], update_taken);
            ghr_q             <= {ghr_q[GHR_W-2:0], update_taken};
        end
    end

endmodule

`default_nettype wire

/* src/hybrid_predictor.sv */
`default_nettype none

module hybrid_predictor #(
    parameter int BTB_IDX_W     = bp_pkg::BTB_IDX_W,
    parameter int GHR_W         = bp_pkg::GHR_W,
    parameter int LHIST_W       = bp_pkg::LHIST_W,
    parameter int LOCAL_IDX_W   = bp_pkg::LOCAL_IDX_W,
    parameter int CHOOSER_IDX_W = bp_pkg::CHOOSER_IDX_W,
    parameter int RAS_DEPTH     = bp_pkg::RAS_DEPTH
) (
    input  wire logic               CLK,
    input  wire logic               RESET,
    input  wire logic               flush,
    input  wire logic               fetch_valid,
    input  wire bp_pkg::addr_t      fetch_pc,
    input  wire bp_pkg::instr_t     fetch_instr,
    input  wire logic               resolve_valid,
    input  wire bp_pkg::addr_t      resolve_pc,
    input  wire bp_pkg::instr_t     resolve_instr,
    input  wire logic               resolve_taken,
    input  wire bp_pkg::addr_t      resolve_target,
    input  wire bp_pkg::pred_bits_t resolve_pred,
    output logic                    pred_valid,
    output logic                    pred_taken,
    output bp_pkg::addr_t           pred_target,
    output bp_pkg::pred_bits_t      pred_bits
);
    import bp_pkg::*;

    logic is_branch, is_jump, is_call, is_return;
    logic res_branch, res_jump;
    logic btb_hit, global_taken, local_taken, use_global, ras_valid;
    logic btb_write, dir_update, chooser_update;
    addr_t btb_target, ras_top;

    logic       nxt_taken;
    addr_t      nxt_target;
    pred_bits_t nxt_bits;

    branch_classify u_fetch_classify (
        .instr(fetch_instr), .is_branch(is_branch), .is_jump(is_jump),
        .is_call(is_call), .is_return(is_return)
    );

    // Resolve side only needs branch and jump
    branch_classify u_resolve_classify (
        .instr(resolve_instr), .is_branch(res_branch), .is_jump(res_jump),
        .is_call(), .is_return()
    );

    assign btb_write      = resolve_valid && (res_branch || res_jump) && resolve_taken;
    assign dir_update     = resolve_valid && res_branch;
    assign chooser_update = dir_update && (resolve_pred[1] != resolve_pred[0]);

    branch_target_buffer #(.BTB_IDX_W(BTB_IDX_W)) u_btb (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .lookup_pc(fetch_pc), .hit(btb_hit), .target(btb_target),
        .write_en(btb_write), .write_pc(resolve_pc), .write_target(resolve_target)
    );

    gshare_predictor #(.GHR_W(GHR_W)) u_gshare (
        .CLK(CLK), .RESET(RESET), .lookup_pc(fetch_pc), .taken(global_taken),
        .update_en(dir_update), .update_pc(resolve_pc), .update_taken(resolve_taken)
    );

    local_history_predictor #(.LHIST_W(LHIST_W), .LOCAL_IDX_W(LOCAL_IDX_W)) u_local (
        .CLK(CLK), .RESET(RESET), .lookup_pc(fetch_pc), .taken(local_taken),
        .update_en(dir_update), .update_pc(resolve_pc), .update_taken(resolve_taken)
    );

    tournament_chooser #(.CHOOSER_IDX_W(CHOOSER_IDX_W)) u_chooser (
        .CLK(CLK), .RESET(RESET), .lookup_pc(fetch_pc), .use_global(use_global),
        .update_en(chooser_update), .update_pc(resolve_pc),
        .global_correct(resolve_pred[1] == resolve_taken)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .push(fetch_valid && is_call), .pop(fetch_valid && is_return),
        .push_addr(fetch_pc + 32'd4), .valid(ras_valid), .top(ras_top)
    );

    // RAS on returns first, then a BTB hit, else fall through
    always_comb begin
        nxt_taken  = 1'b0;
        nxt_target = '0;
        nxt_bits   = '0;
        if (is_return && ras_valid) begin
            nxt_taken  = 1'b1;
            nxt_target = ras_top;
        end else if (btb_hit) begin
            nxt_taken  = is_jump || (is_branch && (use_global ? global_taken : local_taken));
            nxt_target = btb_target;
            nxt_bits   = {global_taken, local_taken};
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pred_valid  <= 1'b0;
            pred_taken  <= 1'b0;
            pred_target <= '0;
            pred_bits   <= '0;
        end else if (flush) begin
            pred_valid  <= 1'b0;
            pred_taken  <= 1'b0;
            pred_target <= '0;
            pred_bits   <= '0;
        end else begin
            pred_valid  <= fetch_valid;
            pred_taken  <= fetch_valid && nxt_taken;   // Idle cycles give zeros
            pred_target <= fetch_valid ? nxt_target : '0;
            pred_bits   <= fetch_valid ? nxt_bits : '0;
        end
    end

endmodule

`default_nettype wire

/* src/local_history_predictor.sv */
`default_nettype none

module local_history_predictor #(
    parameter int LHIST_W     = bp_pkg::LHIST_W,
    parameter int LOCAL_IDX_W = bp_pkg::LOCAL_IDX_W
) (
    input  wire logic          CLK,
    input  wire logic          RESET,
    input  wire bp_pkg::addr_t lookup_pc,
    output logic               taken,
    input  wire logic          update_en,
    input  wire bp_pkg::addr_t update_pc,
    input  wire logic          update_taken
);
    import bp_pkg::*;

    localparam int HIST_ENTRIES = 1 << LOCAL_IDX_W;
    localparam int PHT_ENTRIES  = 1 << LHIST_W;

    typedef logic [LHIST_W-1:0]     lhist_t;
    typedef logic [LOCAL_IDX_W-1:0] lidx_t;

    lhist_t hist_q [HIST_ENTRIES];  // Per-address outcome history
    ctr_t   pht_q  [PHT_ENTRIES];   // Indexed by history alone

    lidx_t  lookup_idx;
    lidx_t  update_idx;
    lhist_t lookup_hist;
    lhist_t update_hist;

    assign lookup_idx  = lookup_pc[LOCAL_IDX_W+1:2];
    assign update_idx  = update_pc[LOCAL_IDX_W+1:2];
    assign lookup_hist = hist_q[lookup_idx];
    assign update_hist = hist_q[update_idx];

    assign taken = pht_q[lookup_hist][1];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < HIST_ENTRIES; i++) begin
                hist_q[i] <= '0;
            end
            for (int j = 0; j < PHT_ENTRIES; j++) begin
                pht_q[j] <= CTR_INIT;
            end
        end else if (update_en) begin
            // Train the counter the old history pointed at
            pht_q[update_hist]  <= ctr_step(pht_q[update_hist], update_taken);
            hist_q[update_idx]  <= {update_hist[LHIST_W-2:0], update_taken};
        end
    end

endmodule

`default_nettype wire

/* src/return_stack.sv */
`default_nettype none

module return_stack #(
    parameter int RAS_DEPTH = bp_pkg::RAS_DEPTH
) (
    input  wire logic          CLK,
    input  wire logic          RESET,
    input  wire logic          flush,
    input  wire logic          push,
    input  wire logic          pop,
    input  wire bp_pkg::addr_t push_addr,
    output logic               valid,
    output bp_pkg::addr_t      top
);
    import bp_pkg::*;

    localparam int PTR_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RAS_DEPTH + 1);

    typedef logic [PTR_W-1:0] ras_ptr_t;
    typedef logic [CNT_W-1:0] ras_cnt_t;

    localparam ras_ptr_t LAST_SLOT = ras_ptr_t'(RAS_DEPTH - 1);
    localparam ras_cnt_t FULL      = ras_cnt_t'(RAS_DEPTH);

    addr_t    stack_q [RAS_DEPTH];
    ras_ptr_t top_q;               // Slot holding the newest entry
    ras_cnt_t count_q;
    ras_ptr_t ptr_up;
    ras_ptr_t ptr_down;

    // Circular wrap in both directions
    assign ptr_up   = (top_q == LAST_SLOT) ? '0 : top_q + 1'b1;
    assign ptr_down = (top_q == '0) ? LAST_SLOT : top_q - 1'b1;

    assign valid = (count_q != '0);
    assign top   = stack_q[top_q];

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            top_q   <= LAST_SLOT;
            count_q <= '0;
        end else if (flush) begin
            count_q <= '0;
        end else if (push) begin
            top_q   <= ptr_up;
            count_q <= (count_q == FULL) ? count_q : count_q + 1'b1;  // Oldest is lost when full
        end else if (pop && valid) begin
            top_q   <= ptr_down;
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (push && !flush) begin
            stack_q[ptr_up] <= push_addr;
        end
    end

endmodule

`default_nettype wire

/* src/tournament_chooser.sv */
`default_nettype none

module tournament_chooser #(
    parameter int CHOOSER_IDX_W = bp_pkg::CHOOSER_IDX_W
) (
    input  wire logic          CLK,
    input  wire logic          RESET,
    input  wire bp_pkg::addr_t lookup_pc,
    output logic               use_global,
    input  wire logic          update_en,
    input  wire bp_pkg::addr_t update_pc,
    input  wire logic          global_correct
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << CHOOSER_IDX_W;

    typedef logic [CHOOSER_IDX_W-1:0] cidx_t;

    ctr_t  sel_q [ENTRIES];  // High half prefers global
    cidx_t lookup_idx;
    cidx_t update_idx;

    assign lookup_idx = lookup_pc[CHOOSER_IDX_W+1:2];
    assign update_idx = update_pc[CHOOSER_IDX_W+1:2];
    assign use_global = sel_q[lookup_idx][1];

    // Only trained when the two predictors disagreed
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                sel_q[i] <= CTR_INIT;
            end
        end else if (update_en) begin
            sel_q[update_idx] <= ctr_step(sel_q[update_idx], global_correct);
        end
    end

endmodule

`default_nettype wire

/* test/tb_hybrid_predictor.sv */
`default_nettype none

module tb_hybrid_predictor;
    timeunit 1ns;
    timeprecision 1ps;
    import bp_pkg::*;

    typedef struct packed {
        logic       valid;
        logic       taken;
        addr_t      target;
        pred_bits_t bits;
    } pred_exp_t;

    localparam instr_t BEQ       = 32'h1000_0010;
    localparam instr_t JMP       = 32'h0800_0040;
    localparam instr_t JAL       = 32'h0C00_0080;
    localparam instr_t JR_RA     = 32'h03E0_0008;
    localparam addr_t  PC_J      = 32'h0040_0100;  // BTB index 0
    localparam addr_t  PC_B      = 32'h0040_0204;
    localparam addr_t  PC_L      = 32'h0040_0310;
    localparam addr_t  PC_M      = 32'h0040_0358;
    localparam addr_t  PC_R      = 32'h0040_05F0;  // Return site
    localparam addr_t  RET_TGT   = 32'h0040_9000;
    localparam addr_t  CALL_BASE = 32'h0040_1000;

    logic       CLK = 1'b0;
    logic       RESET;
    logic       flush;
    logic       fetch_valid;
    addr_t      fetch_pc;
    instr_t     fetch_instr;
    logic       resolve_valid;
    addr_t      resolve_pc;
    instr_t     resolve_instr;
    logic       resolve_taken;
    addr_t      resolve_target;
    pred_bits_t resolve_pred;
    logic       pred_valid;
    logic       pred_taken;
    addr_t      pred_target;
    pred_bits_t pred_bits;

    // Shadow state of the predictor
    logic [(1<<BTB_IDX_W)-1:0] btb_ok;
    addr_t               btb_pc  [1<<BTB_IDX_W];
    addr_t               btb_tgt [1<<BTB_IDX_W];
    logic [GHR_W-1:0]    ghr;
    ctr_t                g_ctr   [1<<GHR_W];
    logic [LHIST_W-1:0]  l_hist  [1<<LOCAL_IDX_W];
    ctr_t                l_ctr   [1<<LHIST_W];
    ctr_t                ch_ctr  [1<<CHOOSER_IDX_W];
    addr_t               ras     [$];   // Newest at the back

    pred_exp_t exp_q [$];
    integer    seed   = 32'he58;

    always #20 CLK = ~CLK;

    hybrid_predictor #(
        .BTB_IDX_W(BTB_IDX_W), .GHR_W(GHR_W), .LHIST_W(LHIST_W),
        .LOCAL_IDX_W(LOCAL_IDX_W), .CHOOSER_IDX_W(CHOOSER_IDX_W), .RAS_DEPTH(RAS_DEPTH)
    ) DUT (
        .CLK(CLK), .RESET(RESET), .flush(flush),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
        .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
        .resolve_instr(resolve_instr), .resolve_taken(resolve_taken),
        .resolve_target(resolve_target), .resolve_pred(resolve_pred),
        .pred_valid(pred_valid), .pred_taken(pred_taken),
        .pred_target(pred_target), .pred_bits(pred_bits)
    );

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // {branch, jump, call, return}
    function automatic logic [3:0] decode(instr_t ins);
        logic [5:0] op;
        logic       ret;
        op  = ins[31:26];
        ret = (op == 6'd0) && (ins[25:21] == 5'd31) && (ins[5:0] == 6'd8);
        return {(op == 6'd1) || (op >= 6'd4 && op <= 6'd7),
                (op == 6'd2) || (op == 6'd3) || ret, op == 6'd3, ret};
    endfunction

    function automatic ctr_t sat_count(ctr_t c, logic up);
        if (up && c != 2'd3) begin
            return c + 2'd1;
        end
        if (!up && c != 2'd0) begin
            return c - 2'd1;
        end
        return c;
    endfunction

    // Raw {global, local} directions for a PC
    function automatic pred_bits_t raw_dirs(addr_t pc);
        logic [GHR_W-1:0]   gi;
        logic [LHIST_W-1:0] h;
        gi = ghr ^ pc[GHR_W+1:2];
        h  = l_hist[pc[LOCAL_IDX_W+1:2]];
        return {g_ctr[gi][1], l_ctr[h][1]};
    endfunction

    // Expected registered outputs for one fetch from the state before the edge
    function automatic pred_exp_t predict(logic fv, logic fl, addr_t pc, instr_t ins);
        pred_exp_t            e;
        logic [3:0]           d;
        logic [BTB_IDX_W-1:0] bi;
        pred_bits_t           dirs;
        logic                 pick_global;
        e           = '0;
        d           = decode(ins);
        bi          = pc[BTB_IDX_W+1:2];
        dirs        = raw_dirs(pc);
        pick_global = ch_ctr[pc[CHOOSER_IDX_W+1:2]][1];
        if (fv && !fl) begin
            e.valid = 1'b1;
            if (d[0] && ras.size() != 0) begin
                e.taken  = 1'b1;
                e.target = ras[$];
            end else if (btb_ok[bi] && btb_pc[bi][31:BTB_IDX_W+2] == pc[31:BTB_IDX_W+2]) begin
                e.taken  = d[2] || (d[3] && (pick_global ? dirs[1] : dirs[0]));
                e.target = btb_tgt[bi];
                e.bits   = dirs;
            end
        end
        return e;
    endfunction

    task automatic reset_model();
        btb_ok = '0;
        ghr    = '0;
        ras.delete();
        for (int i = 0; i < (1 << GHR_W); i++) begin
            g_ctr[i] = 2'd1;
        end
        for (int i = 0; i < (1 << LOCAL_IDX_W); i++) begin
            l_hist[i] = '0;
        end
        for (int i = 0; i < (1 << LHIST_W); i++) begin
            l_ctr[i] = 2'd1;
        end
        for (int i = 0; i < (1 << CHOOSER_IDX_W); i++) begin
            ch_ctr[i] = 2'd1;
        end
    endtask

    // Apply the effect of the coming clock edge to the shadow state
    task automatic train_model();
        logic [3:0]             fd;
        logic [3:0]             rd;
        logic [GHR_W-1:0]       gi;
        logic [LOCAL_IDX_W-1:0] li;
        logic [BTB_IDX_W-1:0]   wi;
        fd = decode(fetch_instr);
        rd = decode(resolve_instr);
        wi = resolve_pc[BTB_IDX_W+1:2];
        if (flush) begin
            ras.delete();
            btb_ok = '0;
        end else begin
            if (fetch_valid && fd[1]) begin
                ras.push_back(fetch_pc + 32'd4);
                if (ras.size() > RAS_DEPTH) begin
                    void'(ras.pop_front());  // Oldest entry lost
                end
            end else if (fetch_valid && fd[0] && ras.size() != 0) begin
                void'(ras.pop_back());
            end
            if (resolve_valid && (rd[3] || rd[2]) && resolve_taken) begin
                btb_ok[wi]  = 1'b1;
                btb_pc[wi]  = resolve_pc;
                btb_tgt[wi] = resolve_target;
            end
        end
        if (resolve_valid && rd[3]) begin
            gi = ghr ^ resolve_pc[GHR_W+1:2];
            li = resolve_pc[LOCAL_IDX_W+1:2];
            if (resolve_pred[1] != resolve_pred[0]) begin
                ch_ctr[resolve_pc[CHOOSER_IDX_W+1:2]] =
                    sat_count(ch_ctr[resolve_pc[CHOOSER_IDX_W+1:2]], resolve_pred[1] == resolve_taken);
            end
            g_ctr[gi]          = sat_count(g_ctr[gi], resolve_taken);
            ghr                = {ghr[GHR_W-2:0], resolve_taken};
            l_ctr[l_hist[li]]  = sat_count(l_ctr[l_hist[li]], resolve_taken);
            l_hist[li]         = {l_hist[li][LHIST_W-2:0], resolve_taken};
        end
    endtask

    // One clock with the inputs as set before going back to idle
    task automatic step();
        exp_q.push_back(predict(fetch_valid, flush, fetch_pc, fetch_instr));
        train_model();
        @(negedge CLK);
        fetch_valid   = 1'b0;
        resolve_valid = 1'b0;
        flush         = 1'b0;
    endtask

    task automatic set_fetch(addr_t pc, instr_t ins);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        fetch_instr = ins;
    endtask

    task automatic set_resolve(addr_t pc, instr_t ins, logic taken, addr_t tgt);
        resolve_valid  = 1'b1;
        resolve_pc     = pc;
        resolve_instr  = ins;
        resolve_taken  = taken;
        resolve_target = tgt;
        resolve_pred   = raw_dirs(pc);  // What was predicted at fetch
    endtask

    function automatic instr_t pick_instr(logic [2:0] kind, logic [15:0] low);
        case (kind)
            3'd0, 3'd1: return {6'd4, 10'd0, low};
            3'd2:       return {6'd5, 10'd0, low};
            3'd3:       return {6'd2, 10'd0, low};
            3'd4:       return {6'd3, 10'd0, low};
            3'd5:       return JR_RA;
            default:    return {6'd0, 10'd0, low};  // ALU op with rs 0
        endcase
    endfunction

    task automatic random_cycle();
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] t;
        r = $random(seed);
        s = $random(seed);
        t = $random(seed);
        fetch_valid    = r[0] | r[1];
        fetch_pc       = 32'h0040_0000 | {22'd0, r[9:2], 2'b00};  // Four tags per index
        fetch_instr    = pick_instr(r[12:10], s[15:0]);
        resolve_valid  = r[13];
        resolve_pc     = 32'h0040_0000 | {22'd0, r[21:14], 2'b00};
        resolve_instr  = pick_instr(r[24:22], s[31:16]);
        resolve_taken  = r[25];
        resolve_target = {t[31:2], 2'b00};
        resolve_pred   = r[27:26];
        flush          = (r[31:28] == 4'd0) && (t[1:0] == 2'b00);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == 20) begin
                $display("Timeout: expected predictions still pending after 20 cycles");
                $display("Test failed");
                $fatal(1, "Timeout");
            end
            @(negedge CLK);
            n++;
        end
    endtask

    // Compare process samples after the outputs settle
    initial begin
        pred_exp_t e;
        forever begin
            @(posedge CLK);
            #1;
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check("pred_valid", 32'(pred_valid), 32'(e.valid));
                check("pred_taken", 32'(pred_taken), 32'(e.taken));
                check("pred_target", pred_target, e.target);
                check("pred_bits", 32'(pred_bits), 32'(e.bits));
            end
        end
    end

    initial begin
        RESET          = 1'b0;
        flush          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        fetch_instr    = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_instr  = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        resolve_pred   = '0;
        reset_model();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b1;

        // Nothing is predicted taken with a cold BTB
        for (int i = 0; i < 6; i++) begin
            if (i != 3) begin
                set_fetch(PC_J + 32'(4 * i), (i % 2 == 0) ? BEQ : JMP);
            end
            step();
            check("pred_valid", 32'(pred_valid), (i == 3) ? 32'd0 : 32'd1);
            check("pred_taken", 32'(pred_taken), 32'd0);
            check("pred_target", pred_target, 32'd0);
        end

        // BTB fill by a jump and a branch
        set_resolve(PC_J, JMP, 1'b1, 32'h0040_8000);
        step();
        set_fetch(PC_J, JMP);
        step();
        check("pred_taken", 32'(pred_taken), 32'd1);
        check("pred_target", pred_target, 32'h0040_8000);
        set_resolve(PC_B, BEQ, 1'b1, 32'h0040_0400);
        step();
        set_fetch(PC_B, BEQ);
        step();
        check("pred_taken", 32'(pred_taken), 32'd0);
        check("pred_target", pred_target, 32'h0040_0400);
        repeat (10) begin
            set_resolve(PC_B, BEQ, 1'b1, 32'h0040_0400);
            step();
        end
        set_fetch(PC_B, BEQ);
        step();
        check("pred_taken", 32'(pred_taken), 32'd1);  // Both histories saturated

        // Two interleaved loop branches train the chooser
        for (int i = 0; i < 64; i++) begin
            set_fetch((i % 3 == 0) ? PC_M : PC_L, BEQ);
            set_resolve((i % 2 == 0) ? PC_L : PC_M, BEQ, (i % 4) != 3, 32'h0040_0500);
            step();
        end

        // Ten calls overflow the 8-deep stack
        set_resolve(PC_R, JR_RA, 1'b1, RET_TGT);
        step();
        for (int i = 0; i < 10; i++) begin
            set_fetch(CALL_BASE + 32'(16 * i), JAL);
            step();
        end
        for (int i = 9; i >= 1; i--) begin
            set_fetch(PC_R, JR_RA);
            step();
            check("pred_taken", 32'(pred_taken), 32'd1);
            check("pred_target", pred_target,
                  (i >= 2) ? CALL_BASE + 32'(16 * i) + 32'd4 : RET_TGT);
        end

        // Flush drops outputs, BTB and RAS
        set_fetch(CALL_BASE, JAL);
        step();
        set_fetch(PC_J, JMP);
        flush = 1'b1;
        step();
        check("pred_valid", 32'(pred_valid), 32'd0);
        set_fetch(PC_J, JMP);
        step();
        check("pred_taken", 32'(pred_taken), 32'd0);
        check("pred_target", pred_target, 32'd0);
        set_fetch(PC_R, JR_RA);
        step();
        check("pred_taken", 32'(pred_taken), 32'd0);

        repeat (3000) begin
            random_cycle();
            step();
        end

        wait_drain();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
